/* verilog/bp_pkg.sv */
package bp_pkg;

  ////////////////////
  // Datapath widths
  ////////////////////
  localparam int pc_w         = 16;  // Instruction address width
  localparam int instr_w      = 16;  // Fetched word width
  localparam int target_lsb_w = 12;  // Branch target field in instr[11:0]

  ////////////////////
  // Predictor tables
  ////////////////////
  localparam int idx_w     = 4;               // Table index, low bits of the PC
  localparam int n_entries = 1 << idx_w;      // One entry per index value
  localparam int ctr_w     = 2;               // Saturating counter width

  // Counter encodings
  localparam logic [ctr_w-1:0] ctr_min   = 2'b00;  // Strongly not taken
  localparam logic [ctr_w-1:0] ctr_reset = 2'b01;  // Weakly not taken
  localparam logic [ctr_w-1:0] ctr_max   = 2'b11;  // Strongly taken

  ////////////////////
  // Instruction set
  ////////////////////
  localparam int opc_w = 4;  // Opcode sits in instr[15:12]

  // Only the opcodes that matter to the front end
  typedef enum logic [opc_w-1:0] {
    op_nop = 4'h0,  // No operation
    op_alu = 4'h1,  // Plain arithmetic, falls through
    op_br  = 4'h2,  // Conditional branch on cond
    op_jmp = 4'h3   // Unconditional jump
  } opcode_t;

  // Remaining codes decode like op_nop

endpackage

/* verilog/branch_history_table.sv */
module branch_history_table import bp_pkg::*; (
  input  logic             clk,            // System clock
  input  logic             arst_n,         // Async reset, active low
  input  logic             enable,         // Global hold when low
  input  logic [idx_w-1:0] rd_idx,         // Fetch PC low bits
  input  logic [idx_w-1:0] wr_idx,         // Decode PC low bits
  input  logic [ctr_w-1:0] wr_prediction,  // Counter value carried with the branch
  input  logic             wen,            // Update request from decode
  input  logic             actual_taken,   // Resolved direction
  output logic [ctr_w-1:0] prediction      // Counter at the fetch index
);

  ////////////////////
  // Counter storage
  ////////////////////
  logic [ctr_w-1:0] ctr_q [n_entries];  // One 2-bit counter per index
  logic [ctr_w-1:0] ctr_step;           // Carried value moved one step

  // Step toward the resolved direction and stop at the ends
  always_comb begin
    if (actual_taken) begin
      if (wr_prediction == ctr_max) begin
        ctr_step = ctr_max;                       // Already saturated high
      end else begin
        ctr_step = wr_prediction + 1'b1;
      end
    end else begin
      if (wr_prediction == ctr_min) begin
        ctr_step = ctr_min;                       // Already saturated low
      end else begin
        ctr_step = wr_prediction - 1'b1;
      end
    end
  end

  // Table write held while enable is low
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < n_entries; i++) begin
        ctr_q[i] <= ctr_reset;                    // All weakly not taken
      end
    end else if (enable && wen) begin
      ctr_q[wr_idx] <= ctr_step;
    end
  end

  ////////////////////
  // Lookup
  ////////////////////
  // Combinational read with the new value visible the cycle after a write
  assign prediction = ctr_q[rd_idx];

endmodule

/* verilog/branch_target_buffer.sv */
module branch_target_buffer import bp_pkg::*; (
  input  logic             clk,               // System clock
  input  logic             arst_n,            // Async reset, active low
  input  logic             enable,            // Global hold when low
  input  logic [idx_w-1:0] rd_idx,            // Fetch PC low bits
  input  logic [idx_w-1:0] wr_idx,            // Decode PC low bits
  input  logic             wen,               // Taken branch in decode
  input  logic [pc_w-1:0]  actual_target,     // Resolved branch target
  output logic [pc_w-1:0]  predicted_target,  // Cached target at fetch index
  output logic             btb_hit            // Entry at fetch index is valid
);

  ////////////////////
  // Entry storage
  ////////////////////
  logic [n_entries-1:0] valid_q;                // One valid bit per entry
  logic [pc_w-1:0]      target_q [n_entries];  // Cached targets

  logic wr_en;  // Qualified write strobe

  assign wr_en = enable & wen;  // No writes while held

  // Valid bits start cleared
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;                            // Nothing cached yet
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Target array written on every taken branch
  always_ff @(posedge clk) begin
    if (wr_en) begin
      target_q[wr_idx] <= actual_target;        // Latest taken target wins
    end
  end

  ////////////////////
  // Lookup
  ////////////////////
  // Both read combinationally from the registered arrays
  assign btb_hit          = valid_q[rd_idx];
  assign predicted_target = target_q[rd_idx];  // Ignored by fetch on a miss

  // Several PCs share an index and may alias
  // Decode catches a wrong target and rewrites the entry

endmodule

/* verilog/branch_predictor.sv */
module branch_predictor import bp_pkg::*; (
  input  logic             clk,                  // System clock
  input  logic             arst_n,               // Async reset, active low
  input  logic             enable,               // Global hold when low
  input  logic [idx_w-1:0] pc_curr,              // Fetch PC low bits
  input  logic [idx_w-1:0] if_id_pc_curr,        // Decode PC low bits
  input  logic [ctr_w-1:0] if_id_prediction,     // Counter carried to decode
  input  logic             was_branch,           // Decode holds a br or jmp
  input  logic             actual_taken,         // Resolved direction
  input  logic             branch_mispredicted,  // Redirect from decode
  input  logic [pc_w-1:0]  actual_target,        // Resolved target
  output logic [ctr_w-1:0] prediction,           // Direction counter for fetch
  output logic [pc_w-1:0]  predicted_target,     // Target for fetch
  output logic             btb_hit               // Target is cached
);

  logic wen_btb;  // Target buffer write
  logic wen_bht;  // History table write

  assign wen_btb = was_branch & actual_taken;         // Every taken branch refreshes the target
  assign wen_bht = was_branch & branch_mispredicted;  // Counters move only on a miss

  ////////////////////
  // Target buffer
  branch_target_buffer u_btb (
    .clk             (clk),
    .arst_n          (arst_n),
    .enable          (enable),
    .rd_idx          (pc_curr),
    .wr_idx          (if_id_pc_curr),
    .wen             (wen_btb),
    .actual_target   (actual_target),
    .predicted_target(predicted_target),
    .btb_hit         (btb_hit)
  );

  ////////////////////
  // History table
  branch_history_table u_bht (
    .clk          (clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .rd_idx       (pc_curr),
    .wr_idx       (if_id_pc_curr),
    .wr_prediction(if_id_prediction),
    .wen          (wen_bht),
    .actual_taken (actual_taken),
    .prediction   (prediction)
  );

endmodule

/* verilog/fetch_stage.sv */
module fetch_stage import bp_pkg::*; (
  input  logic               clk,                 // System clock
  input  logic               arst_n,              // Async reset, active low
  input  logic               enable,              // Global hold when low
  input  logic [instr_w-1:0] instr,               // Word at pc, same cycle
  input  logic [ctr_w-1:0]   prediction,          // Counter for pc
  input  logic [pc_w-1:0]    predicted_target,    // Cached target for pc
  input  logic               btb_hit,             // Target is valid
  input  logic               redirect,            // Mispredict from decode
  input  logic [pc_w-1:0]    redirect_pc,         // Correct path restart
  output logic [pc_w-1:0]    pc,                  // Fetch address
  output logic               if_id_valid,         // Decode slot occupied
  output logic [pc_w-1:0]    if_id_pc,            // PC of decode slot
  output logic [instr_w-1:0] if_id_instr,         // Word in decode slot
  output logic [ctr_w-1:0]   if_id_prediction,    // Counter seen at fetch
  output logic               if_id_pred_taken,    // Fetch followed the target
  output logic [pc_w-1:0]    if_id_pred_target    // Target seen at fetch
);

  logic [pc_w-1:0] pc_q;        // Program counter
  logic [pc_w-1:0] pc_next;     // Next fetch address
  logic            pred_taken;  // Predicted taken with a usable target

  assign pc         = pc_q;
  assign pred_taken = prediction[ctr_w-1] & btb_hit;  // Counter msb and a hit

  ////////////////////
  // Next PC
  ////////////////////
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;            // Decode correction first
    end else if (pred_taken) begin
      pc_next = predicted_target;       // Follow the predictor
    end else begin
      pc_next = pc_q + 1'b1;            // Sequential
    end
  end

  // Control state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q        <= '0;
      if_id_valid <= 1'b0;              // Empty pipe out of reset
    end else if (enable) begin
      pc_q        <= pc_next;
      if_id_valid <= ~redirect;         // Squash the wrong-path word
    end
  end

  ////////////////////
  // IF/ID payload
  ////////////////////
  always_ff @(posedge clk) begin
    if (enable) begin
      if_id_pc          <= pc_q;
      if_id_instr       <= instr;
      if_id_prediction  <= prediction;  // Needed for the counter update
      if_id_pred_taken  <= pred_taken;
      if_id_pred_target <= predicted_target;
    end
  end

endmodule

/* verilog/decode_stage.sv */
module decode_stage import bp_pkg::*; (
  input  logic               if_id_valid,        // Decode slot occupied
  input  logic [pc_w-1:0]    if_id_pc,           // PC of decode slot
  input  logic [instr_w-1:0] if_id_instr,        // Word in decode slot
  input  logic [ctr_w-1:0]   if_id_prediction,   // Counter seen at fetch
  input  logic               if_id_pred_taken,   // Fetch followed the target
  input  logic [pc_w-1:0]    if_id_pred_target,  // Target seen at fetch
  input  logic               cond,               // Branch condition level
  input  logic               enable,             // Global hold when low
  output logic               redirect,           // Mispredict pulse
  output logic               was_branch,         // br or jmp in decode
  output logic               actual_taken,       // Resolved direction
  output logic [pc_w-1:0]    redirect_pc,        // Correct next PC
  output logic [pc_w-1:0]    actual_target,      // Target field, zero extended
  output logic               retire_valid,       // Instruction leaves decode
  output logic [pc_w-1:0]    retire_pc           // Its PC
);

  opcode_t         opcode;       // Decoded opcode field
  logic            live;         // Slot counts this cycle
  logic            is_branch;    // Ungated branch flag
  logic            taken;        // Ungated direction
  logic            mispred;      // Ungated verdict
  logic [pc_w-1:0] target;       // Ungated target
  logic [pc_w-1:0] seq_pc;       // Fall-through PC

  assign opcode = opcode_t'(if_id_instr[instr_w-1 -: opc_w]);
  assign live   = if_id_valid & enable;            // Nothing moves on a hold
  assign seq_pc = if_id_pc + 1'b1;
  assign target = {{(pc_w-target_lsb_w){1'b0}}, if_id_instr[target_lsb_w-1:0]};

  ////////////////////
  // Branch resolution
  ////////////////////
  always_comb begin
    case (opcode)
      op_br: begin
        is_branch = 1'b1;
        taken     = cond;                          // Sampled here in decode
      end
      op_jmp: begin
        is_branch = 1'b1;
        taken     = 1'b1;                          // Always taken
      end
      op_nop, op_alu: begin
        is_branch = 1'b0;
        taken     = 1'b0;
      end
      default: begin
        is_branch = 1'b0;                          // Unused codes act as nop
        taken     = 1'b0;
      end
    endcase
  end

  // Wrong direction, wrong target, or a non-branch that fetch jumped on
  assign mispred = is_branch ? ((taken != if_id_pred_taken) ||
                                (taken && if_id_pred_taken && (target != if_id_pred_target)))
                             : if_id_pred_taken;

  ////////////////////
  // Gated outputs
  ////////////////////
  assign redirect      = live & mispred;
  assign redirect_pc   = live ? (taken ? target : seq_pc) : '0;
  assign was_branch    = live & is_branch;
  assign actual_taken  = live & taken;
  assign actual_target = live ? target : '0;
  assign retire_valid  = live;                     // One cycle after fetch
  assign retire_pc     = live ? if_id_pc : '0;

endmodule

/* verilog/fetch_decode_top.sv */
module fetch_decode_top import bp_pkg::*; (
  input  logic               clk,           // System clock
  input  logic               arst_n,        // Async reset, active low
  input  logic               enable,        // Global hold when low
  input  logic               cond,          // Branch condition level
  input  logic [instr_w-1:0] instr,         // Instruction memory data
  output logic [pc_w-1:0]    pc,            // Instruction memory address
  output logic               retire_valid,  // Instruction retires
  output logic [pc_w-1:0]    retire_pc,     // Retired PC
  output logic               mispredict     // Decode redirect
);

  logic [ctr_w-1:0]   prediction;           // Predictor to fetch
  logic [pc_w-1:0]    predicted_target;
  logic               btb_hit;
  logic               if_id_valid;          // IF/ID register
  logic [pc_w-1:0]    if_id_pc;
  logic [instr_w-1:0] if_id_instr;
  logic [ctr_w-1:0]   if_id_prediction;
  logic               if_id_pred_taken;
  logic [pc_w-1:0]    if_id_pred_target;
  logic               redirect;             // Decode back to fetch
  logic [pc_w-1:0]    redirect_pc;
  logic               was_branch;           // Decode to predictor
  logic               actual_taken;
  logic [pc_w-1:0]    actual_target;

  assign mispredict = redirect;

  fetch_stage u_fetch (
    .clk(clk), .arst_n(arst_n), .enable(enable), .instr(instr),
    .prediction(prediction), .predicted_target(predicted_target), .btb_hit(btb_hit),
    .redirect(redirect), .redirect_pc(redirect_pc), .pc(pc),
    .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_instr(if_id_instr),
    .if_id_prediction(if_id_prediction), .if_id_pred_taken(if_id_pred_taken),
    .if_id_pred_target(if_id_pred_target)
  );

  branch_predictor u_bp (
    .clk(clk), .arst_n(arst_n), .enable(enable),
    .pc_curr(pc[idx_w-1:0]), .if_id_pc_curr(if_id_pc[idx_w-1:0]),  // Index by PC low bits
    .if_id_prediction(if_id_prediction), .was_branch(was_branch),
    .actual_taken(actual_taken), .branch_mispredicted(redirect),
    .actual_target(actual_target), .prediction(prediction),
    .predicted_target(predicted_target), .btb_hit(btb_hit)
  );

  decode_stage u_decode (
    .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_instr(if_id_instr),
    .if_id_prediction(if_id_prediction), .if_id_pred_taken(if_id_pred_taken),
    .if_id_pred_target(if_id_pred_target), .cond(cond), .enable(enable),
    .redirect(redirect), .was_branch(was_branch), .actual_taken(actual_taken),
    .redirect_pc(redirect_pc), .actual_target(actual_target),
    .retire_valid(retire_valid), .retire_pc(retire_pc)
  );

endmodule

/* verification/clock_gen.sv */
module clock_gen (
  output logic clk,    // 100 ns period
  output logic arst_n  // Async reset, active low
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;         // Half period
  end

  // Clean falling edge before the first clock, then low over 5 rising edges
  initial begin
    arst_n = 1'b1;
    #1 arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk) arst_n = 1'b1;   // Release away from the active edge
  end

endmodule

/* verification/tb_fetch_decode.sv */
module tb_fetch_decode import bp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic               clk, arst_n, enable, cond;     // DUT inputs
  logic [instr_w-1:0] instr;
  logic [pc_w-1:0]    pc, retire_pc;                 // DUT outputs
  logic               retire_valid, mispredict;
  logic [31:0]        lfsr;                          // Galois LFSR state
  logic [15:0]        prog [64];                     // Instruction memory

  ////////////////////
  // Reference model
  ////////////////////
  logic [ctr_w-1:0]     m_ctr [n_entries];           // Mirror of the history table
  logic [n_entries-1:0] m_valid;                     // Mirror of the target buffer
  logic [pc_w-1:0]      m_tgt [n_entries];
  logic [pc_w-1:0]      m_pc, m_if_pc, m_if_ptgt, arch_next;
  logic [ctr_w-1:0]     m_if_ctr, f_ctr;
  logic                 m_if_valid, m_if_pt, f_pt;
  logic [15:0]          d_instr;                     // Scratch for one edge
  logic [pc_w-1:0]      d_tgt, d_next, f_tgt;
  opcode_t              d_op;
  logic                 d_branch, d_taken, d_live, d_miss;
  int                   loop_streak;                 // Taken runs of the loop branch at 20

  clock_gen u_clk (.clk(clk), .arst_n(arst_n));

  fetch_decode_top dut0 (
    .clk(clk), .arst_n(arst_n), .enable(enable), .cond(cond), .instr(instr), .pc(pc),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .mispredict(mispredict)
  );

  assign instr = prog[pc[5:0]];  // Same-cycle memory, 64 words wrap

  // One LFSR step per bit handed out
  function automatic logic [31:0] draw(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // 2-bit saturating step toward the outcome
  function automatic logic [1:0] counter_step(input logic [1:0] ctr, input logic up);
    if (up) return (ctr == 2'd3) ? 2'd3 : ctr + 2'd1;
    return (ctr == 2'd0) ? 2'd0 : ctr - 2'd1;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("Error at %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
    abort_run();
  endtask

  // Random mix where every jmp lands on the loop head so no path is trapped
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] t;
    for (int i = 0; i < 64; i++) begin
      r = draw(3);
      t = draw(12);
      case (r[2:0])
        3'd3:       prog[i] = {op_nop, t[11:0]};
        3'd4, 3'd5: prog[i] = {op_br, 6'd0, t[5:0]};  // Target inside the program
        3'd6:       prog[i] = {op_jmp, 12'd16};
        default:    prog[i] = {op_alu, t[11:0]};
      endcase
    end
    for (int i = 16; i < 20; i++) prog[i] = {op_alu, 12'd0};  // Straight loop body
    prog[20] = {op_br, 12'd16};                               // Loop back 4
    prog[4]  = {op_alu, 12'd0};                               // No alias at index 4
    prog[36] = {op_alu, 12'd0};
    prog[52] = {op_alu, 12'd0};
  endtask

  task automatic reset_model();
    for (int i = 0; i < n_entries; i++) begin
      m_ctr[i] = ctr_reset;
      m_tgt[i] = '0;
    end
    m_valid     = '0;
    m_pc        = '0;
    m_if_valid  = 1'b0;
    m_if_pc     = '0;
    m_if_pt     = 1'b0;
    m_if_ptgt   = '0;
    m_if_ctr    = ctr_reset;
    arch_next   = '0;    // First retire is PC 0
    loop_streak = 0;
  endtask

  // Stimulus with enable low about 1 cycle in 8
  always @(posedge clk) begin
    enable <= (draw(3) != 32'd0);
    cond   <= (draw(1) != 32'd0);
  end

  ////////////////////
  // Checks on each rising edge where inputs and outputs still hold pre-edge values
  ////////////////////
  always @(posedge clk) begin
    if (!arst_n) begin
      assert (pc == '0) else report_mismatch("pc", '0, pc);
      assert (!retire_valid) else report_mismatch("retire_valid", '0, 16'(retire_valid));
      assert (!mispredict) else report_mismatch("mispredict", '0, 16'(mispredict));
      reset_model();
    end else begin
      d_instr  = prog[m_if_pc[5:0]];                         // Decode slot
      d_op     = opcode_t'(d_instr[15:12]);
      d_branch = (d_op == op_br) || (d_op == op_jmp);
      d_taken  = (d_op == op_jmp) || ((d_op == op_br) && cond);
      d_tgt    = {4'd0, d_instr[11:0]};
      d_next   = d_taken ? d_tgt : m_if_pc + 16'd1;
      d_live   = m_if_valid && enable;
      d_miss   = d_live && (d_branch ? ((d_taken != m_if_pt) || (d_taken && m_if_ptgt != d_tgt))
                                     : m_if_pt);
      f_ctr    = m_ctr[m_pc[3:0]];                           // Fetch reads before writes
      f_pt     = f_ctr[1] && m_valid[m_pc[3:0]];
      f_tgt    = m_tgt[m_pc[3:0]];
      // Expected pc also covers the redirect target and the hold
      assert (pc == m_pc) else report_mismatch("pc", m_pc, pc);
      assert (mispredict == d_miss)
        else report_mismatch("mispredict", 16'(d_miss), 16'(mispredict));
      assert (retire_valid == d_live)                        // Low on a hold and after a squash
        else report_mismatch("retire_valid", 16'(d_live), 16'(retire_valid));
      if (d_live) begin
        assert (retire_pc == m_if_pc) else report_mismatch("retire_pc", m_if_pc, retire_pc);
        assert (retire_pc == arch_next)                      // Architectural path only
          else report_mismatch("retire_pc", arch_next, retire_pc);
        arch_next = d_next;
        if (m_if_pc[5:0] == 6'd20) begin                     // Trained loop must predict
          if (d_taken && loop_streak >= 2) begin
            assert (!mispredict) else report_mismatch("mispredict", '0, 16'(mispredict));
          end
          loop_streak = d_taken ? loop_streak + 1 : 0;
        end
      end
      if (enable) begin                                      // Tables and pipe hold otherwise
        if (d_live && d_branch && d_taken) begin
          m_valid[m_if_pc[3:0]] = 1'b1;
          m_tgt[m_if_pc[3:0]]   = d_tgt;
        end
        if (d_miss && d_branch) m_ctr[m_if_pc[3:0]] = counter_step(m_if_ctr, d_taken);
        m_if_valid = !d_miss;
        m_if_pc    = m_pc;
        m_if_pt    = f_pt;
        m_if_ptgt  = f_tgt;
        m_if_ctr   = f_ctr;
        m_pc       = d_miss ? d_next : (f_pt ? f_tgt : m_pc + 16'd1);
      end
    end
  end

  initial begin
    enable = 1'b1;
    cond   = 1'b0;
    lfsr   = 32'h1b6ee0c2;
    build_program();
    repeat (2000) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

  // Watchdog over 2100 cycles of 100 ns
  initial begin
    #(2100 * 100);
    $display("Timeout: the run did not finish within 2100 cycles");
    abort_run();
  end

endmodule

/* flist.f */
verilog/bp_pkg.sv
verilog/branch_history_table.sv
verilog/branch_target_buffer.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/fetch_decode_top.sv
verification/clock_gen.sv
verification/tb_fetch_decode.sv

/* Makefile */
# Verilator flow for the fetch and decode front end

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module fetch_decode_top -f flist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_fetch_decode -f flist.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
